//--- dv/mmu_cp0_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmu_cp0_cfg.svh"

module mmu_cp0_checker (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cpu_pause_i,
	input  logic                   cp0_wen_i,
	input  logic [4:0]             cp0_addr_i,
	input  logic [31:0]            cp0_wdata_i,
	input  mmu_cp0_pkg::tlb_op_e   tlb_op_i,
	input  mmu_cp0_pkg::xlat_req_t xlat_req_i,
	input  mmu_cp0_pkg::exc_req_t  exc_req_i,
	input  logic [5:0]             hw_int_i,
	input  logic [31:0]            cp0_rdata_i,
	input  mmu_cp0_pkg::xlat_rsp_t xlat_rsp_i,
	input  mmu_cp0_pkg::exc_rec_t  exc_i,
	input  logic                   intr_i,
	input  mmu_cp0_pkg::status_t   status_i,
	input  logic [31:0]            epc_i,
	output int                     checks_o,
	output int                     errors_o
);

	// Config fields M, BE, AT, AR, MT, four zero bits and K0
	localparam logic [31:0] CONFIG_WORD = {1'b1, 15'b0, 1'b0, 2'b0, 3'b0, 3'd1, 4'b0, 3'd2};

	int          n_checks = 0;
	int          n_errors = 0;
	logic        started = 1'b0;

	// Register model
	logic        idx_p;
	logic [3:0]  idx;
	logic [3:0]  rnd;
	logic [3:0]  wired;
	logic [31:0] entryhi;
	logic [31:0] lo0;
	logic [31:0] lo1;
	logic [31:0] status;
	logic [5:0]  cause_ip;
	logic [4:0]  cause_code;
	logic [31:0] badvaddr;
	logic [31:0] epc;

	// TLB model with halves held as {pfn, d, v}
	logic        t_used [`MMU_TLB_ENTRIES];
	logic [18:0] t_vpn2 [`MMU_TLB_ENTRIES];
	logic [7:0]  t_asid [`MMU_TLB_ENTRIES];
	logic [21:0] t_even [`MMU_TLB_ENTRIES];
	logic [21:0] t_odd [`MMU_TLB_ENTRIES];

	assign checks_o = n_checks;
	assign errors_o = n_errors;

	// Lowest matching entry or -1 on a miss
	function automatic int find_entry(input logic [18:0] vpn2, input logic [7:0] asid);
		int found;
		found = -1;
		for (int i = 0; i < `MMU_TLB_ENTRIES; i++)
		begin
			if (found < 0 && t_used[i] && t_vpn2[i] == vpn2 && t_asid[i] == asid)
				found = i;
		end
		return found;
	endfunction

	function automatic mmu_cp0_pkg::xlat_rsp_t translate(input mmu_cp0_pkg::xlat_req_t req);
		mmu_cp0_pkg::xlat_rsp_t r;
		int                     hit_idx;
		logic [21:0]            half;
		r = '0;
		r.addr_err = req.vaddr[31];
		hit_idx = find_entry(req.vaddr[31:13], entryhi[7:0]);
		if (req.vaddr[31:30] == 2'b10)
		begin
			r.paddr = {3'b000, req.vaddr[28:0]};
			r.hit = 1'b1;
		end
		else if (hit_idx < 0)
			r.refill = 1'b1;
		else
		begin
			half = req.vaddr[12] ? t_odd[hit_idx] : t_even[hit_idx];
			if (!half[0])
				r.invalid = 1'b1;
			else
			begin
				r.paddr = {half[21:2], req.vaddr[11:0]};
				r.hit = 1'b1;
				r.modified = req.store && !half[1];
			end
		end
		return r;
	endfunction

	function automatic mmu_cp0_pkg::exc_rec_t rank_exception(input mmu_cp0_pkg::xlat_rsp_t rsp);
		mmu_cp0_pkg::exc_rec_t e;
		logic [5:0]            pending;
		logic                  intr;
		logic                  ade;
		logic                  mod;
		logic                  miss;
		pending = hw_int_i & status[15:10];
		intr = (|pending) && status[0] && !status[1];
		ade = xlat_req_i.valid && rsp.addr_err && status[4];
		mod = xlat_req_i.valid && rsp.modified;
		miss = xlat_req_i.valid && (rsp.refill || rsp.invalid);
		e = '0;
		e.valid = !cpu_pause_i && (intr || ade || mod || miss || exc_req_i.syscall);
		e.is_intr = intr;
		e.is_addr = !intr && (ade || mod || miss);
		e.ip = pending;
		e.badvaddr = xlat_req_i.vaddr;
		if (intr)
			e.code = `EXC_INT;
		else if (ade)
			e.code = xlat_req_i.store ? `EXC_ADES : `EXC_ADEL;
		else if (mod)
			e.code = `EXC_MOD;
		else if (miss)
			e.code = xlat_req_i.store ? `EXC_TLBS : `EXC_TLBL;
		else if (exc_req_i.syscall)
			e.code = `EXC_SYS;
		return e;
	endfunction

	function automatic logic [31:0] read_reg(input logic [4:0] addr);
		case (addr)
			`CP0_INDEX_ADDR:    return {idx_p, 27'b0, idx};
			`CP0_RANDOM_ADDR:   return {28'b0, rnd};
			`CP0_ENTRYLO0_ADDR: return lo0;
			`CP0_ENTRYLO1_ADDR: return lo1;
			`CP0_WIRED_ADDR:    return {28'b0, wired};
			`CP0_BADVADDR_ADDR: return badvaddr;
			`CP0_ENTRYHI_ADDR:  return entryhi;
			`CP0_STATUS_ADDR:   return status;
			`CP0_CAUSE_ADDR:    return {16'b0, cause_ip, 3'b0, cause_code, 2'b0};
			`CP0_EPC_ADDR:      return epc;
			`CP0_CONFIG_ADDR:   return CONFIG_WORD;
			default:            return 32'b0;
		endcase
	endfunction

	task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic reset_model();
		started = 1'b1;
		idx_p = 1'b0;
		idx = '0;
		rnd = 4'hf;
		wired = '0;
		entryhi = '0;
		lo0 = '0;
		lo1 = '0;
		status = '0;
		cause_ip = '0;
		cause_code = '0;
		badvaddr = '0;
		epc = '0;
		for (int i = 0; i < `MMU_TLB_ENTRIES; i++)
			t_used[i] = 1'b0;
	endtask

	// One clock edge of the model from the state before the edge
	task automatic advance(input mmu_cp0_pkg::exc_rec_t ex);
		logic [3:0]  old_rnd;
		logic [3:0]  rd;
		logic [3:0]  w_idx;
		logic        was_exl;
		logic        tlbr;
		int          probe;
		logic [21:0] half;
		old_rnd = rnd;
		rnd = (rnd == 4'hf) ? wired : rnd + 4'd1;
		if (cpu_pause_i)
			return;
		rd = idx;
		was_exl = status[1];
		tlbr = (tlb_op_i == mmu_cp0_pkg::TLBR);
		probe = find_entry(entryhi[31:13], entryhi[7:0]);

		if (tlb_op_i == mmu_cp0_pkg::TLBWI || tlb_op_i == mmu_cp0_pkg::TLBWR)
		begin
			w_idx = (tlb_op_i == mmu_cp0_pkg::TLBWR) ? old_rnd : idx;
			t_used[w_idx] = 1'b1;
			t_vpn2[w_idx] = entryhi[31:13];
			t_asid[w_idx] = entryhi[7:0];
			t_even[w_idx] = {lo0[25:6], lo0[2:1]};
			t_odd[w_idx] = {lo1[25:6], lo1[2:1]};
		end

		if (cp0_wen_i && cp0_addr_i == `CP0_INDEX_ADDR)
			idx = cp0_wdata_i[3:0];
		else if (tlb_op_i == mmu_cp0_pkg::TLBP)
		begin
			idx_p = (probe < 0);
			idx = (probe < 0) ? 4'd0 : 4'(probe);
		end

		if (cp0_wen_i && cp0_addr_i == `CP0_WIRED_ADDR)
			wired = cp0_wdata_i[3:0];

		if (cp0_wen_i && cp0_addr_i == `CP0_ENTRYLO0_ADDR)
			lo0 = cp0_wdata_i & 32'h03ff_ffff;
		else if (tlbr)
		begin
			half = t_even[rd];
			lo0 = {6'b0, half[21:2], lo0[5:3], half[1], half[0] & t_used[rd], lo0[0]};
		end
		if (cp0_wen_i && cp0_addr_i == `CP0_ENTRYLO1_ADDR)
			lo1 = cp0_wdata_i & 32'h03ff_ffff;
		else if (tlbr)
		begin
			half = t_odd[rd];
			lo1 = {6'b0, half[21:2], lo1[5:3], half[1], half[0] & t_used[rd], lo1[0]};
		end

		if (cp0_wen_i && cp0_addr_i == `CP0_ENTRYHI_ADDR)
			entryhi = cp0_wdata_i & 32'hffff_e0ff;
		else if (tlbr)
			entryhi = {t_vpn2[rd], 5'b0, t_asid[rd]};
		if (ex.valid && ex.is_addr)
			entryhi[31:13] = xlat_req_i.vaddr[31:13];

		if (cp0_wen_i && cp0_addr_i == `CP0_STATUS_ADDR)
			status = cp0_wdata_i & 32'h0000_fc13;
		if (ex.valid)
			status[1] = 1'b1;
		else if (exc_req_i.eret)
			status[1] = 1'b0;

		if (ex.valid)
		begin
			cause_code = ex.code;
			if (ex.is_intr)
				cause_ip = ex.ip;
			if (ex.is_addr)
				badvaddr = xlat_req_i.vaddr;
			if (!was_exl)
				epc = exc_req_i.epc;
		end
		else if (cp0_wen_i)
		begin
			if (cp0_addr_i == `CP0_CAUSE_ADDR)
			begin
				cause_ip = cp0_wdata_i[15:10];
				cause_code = cp0_wdata_i[6:2];
			end
			if (cp0_addr_i == `CP0_BADVADDR_ADDR)
				badvaddr = cp0_wdata_i;
			if (cp0_addr_i == `CP0_EPC_ADDR)
				epc = cp0_wdata_i;
		end
	endtask

	always @(posedge clk)
	begin : model_step
		mmu_cp0_pkg::xlat_rsp_t rsp;
		mmu_cp0_pkg::exc_rec_t  ex;
		rsp = translate(xlat_req_i);
		ex = rank_exception(rsp);
		// Outputs still show the cycle before this edge
		if (started && !reset)
		begin
			compare("read data", 64'(cp0_rdata_i), 64'(read_reg(cp0_addr_i)));
			compare("translation", 64'(xlat_rsp_i), 64'(rsp));
			compare("exception record", 64'(exc_i), 64'(ex));
			compare("interrupt request", 64'(intr_i), 64'(ex.is_intr));
			compare("status", 64'(status_i), 64'(status));
			compare("epc", 64'(epc_i), 64'(epc));
		end
		if (reset)
			reset_model();
		else if (started)
			advance(ex);
	end

endmodule

`default_nettype wire

//--- dv/mmu_cp0_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmu_cp0_cfg.svh"

module mmu_cp0_tb;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int MOVE_CYCLES = 300;
	localparam int RANDOM_CYCLES = 150;
	localparam int FILL_CYCLES = `MMU_TLB_ENTRIES * 5;
	localparam int TLB_CYCLES = 300;
	localparam int XLAT_CYCLES = 300;
	localparam int EXC_CYCLES = 400;
	localparam int PAUSE_CYCLES = 100;
	// Phase lengths plus the status setup and one idle cycle per phase
	localparam int TOTAL_CYCLES = RESET_CYCLES + MOVE_CYCLES + RANDOM_CYCLES + FILL_CYCLES +
		TLB_CYCLES + XLAT_CYCLES + EXC_CYCLES + PAUSE_CYCLES + 20;

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   cpu_pause;
	logic                   cp0_wen;
	logic [4:0]             cp0_addr;
	mmu_cp0_pkg::cp0_word_u cp0_wdata;
	mmu_cp0_pkg::tlb_op_e   tlb_op;
	mmu_cp0_pkg::xlat_req_t xlat_req;
	mmu_cp0_pkg::exc_req_t  exc_req;
	logic [5:0]             hw_int;
	logic [31:0]            cp0_rdata;
	mmu_cp0_pkg::xlat_rsp_t xlat_rsp;
	mmu_cp0_pkg::exc_rec_t  exc;
	logic                   intr;
	mmu_cp0_pkg::status_t   status;
	logic [31:0]            epc;
	int                     checks;
	int                     errors;
	int                     mark_checks = 0;
	int                     mark_errors = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	mmu_cp0_top UUT (
		.clk(clk),
		.reset(reset),
		.cpu_pause_i(cpu_pause),
		.cp0_wen_i(cp0_wen),
		.cp0_addr_i(cp0_addr),
		.cp0_wdata_i(cp0_wdata),
		.tlb_op_i(tlb_op),
		.xlat_req_i(xlat_req),
		.exc_req_i(exc_req),
		.hw_int_i(hw_int),
		.cp0_rdata_o(cp0_rdata),
		.xlat_rsp_o(xlat_rsp),
		.exc_o(exc),
		.intr_o(intr),
		.status_o(status),
		.epc_o(epc)
	);

	mmu_cp0_checker u_check (
		.clk(clk),
		.reset(reset),
		.cpu_pause_i(cpu_pause),
		.cp0_wen_i(cp0_wen),
		.cp0_addr_i(cp0_addr),
		.cp0_wdata_i(cp0_wdata.raw),
		.tlb_op_i(tlb_op),
		.xlat_req_i(xlat_req),
		.exc_req_i(exc_req),
		.hw_int_i(hw_int),
		.cp0_rdata_i(cp0_rdata),
		.xlat_rsp_i(xlat_rsp),
		.exc_i(exc),
		.intr_i(intr),
		.status_i(status),
		.epc_i(epc),
		.checks_o(checks),
		.errors_o(errors)
	);

	task automatic set_idle();
		cpu_pause = 1'b0;
		cp0_wen = 1'b0;
		cp0_addr = '0;
		cp0_wdata.raw = '0;
		tlb_op = mmu_cp0_pkg::NONE;
		xlat_req = '0;
		exc_req = '0;
		hw_int = '0;
	endtask

	task automatic move_write(input logic [4:0] addr, input logic [31:0] data);
		@(negedge clk);
		set_idle();
		cp0_wen = 1'b1;
		cp0_addr = addr;
		cp0_wdata.raw = data;
	endtask

	task automatic tlb_cmd(input mmu_cp0_pkg::tlb_op_e op);
		@(negedge clk);
		set_idle();
		tlb_op = op;
	endtask

	// Small VPN2 and ASID pool so probes and lookups hit often
	function automatic logic [31:0] pick_entryhi();
		return {16'h0000, 3'($urandom), 5'($urandom), 7'b0, 1'($urandom)};
	endfunction

	function automatic logic [31:0] pick_vaddr();
		case ($urandom % 4)
			0:       return {2'b10, 30'($urandom)};
			1, 2:    return {16'h0000, 3'($urandom), 1'($urandom), 12'($urandom)};
			default: return $urandom;
		endcase
	endfunction

	function automatic logic [4:0] tlb_reg_addr();
		case ($urandom % 4)
			0:       return `CP0_INDEX_ADDR;
			1:       return `CP0_ENTRYHI_ADDR;
			2:       return `CP0_ENTRYLO0_ADDR;
			default: return `CP0_ENTRYLO1_ADDR;
		endcase
	endfunction

	task automatic report_phase(input string name);
		@(negedge clk);
		set_idle();
		$display("%-22s %s  (%0d checks, %0d errors)", name,
			(errors == mark_errors) ? "ok" : "ERRORS", checks - mark_checks, errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	task automatic exercise_moves();
		for (int i = 0; i < MOVE_CYCLES; i++)
		begin
			@(negedge clk);
			set_idle();
			cp0_addr = 5'($urandom);
			cp0_wen = 1'($urandom);
			cp0_wdata.raw = $urandom;
		end
		report_phase("move port");
	endtask

	task automatic watch_random();
		for (int i = 0; i < RANDOM_CYCLES; i++)
		begin
			@(negedge clk);
			set_idle();
			cp0_addr = `CP0_RANDOM_ADDR;
			cpu_pause = ($urandom % 4) == 0;
			if ($urandom % 25 == 0)
			begin
				cp0_wen = 1'b1;
				cp0_addr = `CP0_WIRED_ADDR;
				cp0_wdata.raw = {28'b0, 4'($urandom)};
			end
		end
		report_phase("random register");
	endtask

	task automatic tlb_ops();
		// Every entry written first so TLBR never reads an empty slot
		for (int i = 0; i < `MMU_TLB_ENTRIES; i++)
		begin
			move_write(`CP0_INDEX_ADDR, i);
			move_write(`CP0_ENTRYHI_ADDR, pick_entryhi());
			move_write(`CP0_ENTRYLO0_ADDR, $urandom);
			move_write(`CP0_ENTRYLO1_ADDR, $urandom);
			tlb_cmd(mmu_cp0_pkg::TLBWI);
		end
		for (int i = 0; i < TLB_CYCLES; i++)
		begin
			@(negedge clk);
			set_idle();
			cp0_addr = tlb_reg_addr();
			case ($urandom % 8)
				0:
				begin
					cp0_wen = 1'b1;
					cp0_addr = `CP0_INDEX_ADDR;
					cp0_wdata.raw = $urandom;
				end
				1:
				begin
					cp0_wen = 1'b1;
					cp0_addr = `CP0_ENTRYHI_ADDR;
					cp0_wdata.raw = pick_entryhi() | ($urandom & 32'h0000_1f00);
				end
				2:
				begin
					cp0_wen = 1'b1;
					cp0_addr = ($urandom % 2) ? `CP0_ENTRYLO0_ADDR : `CP0_ENTRYLO1_ADDR;
					cp0_wdata.raw = $urandom;
				end
				3:       tlb_op = mmu_cp0_pkg::TLBP;
				4:       tlb_op = mmu_cp0_pkg::TLBR;
				5:       tlb_op = mmu_cp0_pkg::TLBWI;
				6:       tlb_op = mmu_cp0_pkg::TLBWR;
				default: tlb_op = mmu_cp0_pkg::NONE;
			endcase
		end
		report_phase("tlb write and probe");
	endtask

	task automatic translate_addresses();
		move_write(`CP0_STATUS_ADDR, 32'h0);
		for (int i = 0; i < XLAT_CYCLES; i++)
		begin
			@(negedge clk);
			set_idle();
			xlat_req.valid = 1'b1;
			xlat_req.store = 1'($urandom);
			xlat_req.vaddr = pick_vaddr();
			exc_req.eret = ($urandom % 4) == 0;
			cp0_addr = ($urandom % 2) ? `CP0_BADVADDR_ADDR : `CP0_ENTRYHI_ADDR;
			if ($urandom % 10 == 0)
			begin
				cp0_wen = 1'b1;
				cp0_addr = `CP0_ENTRYHI_ADDR;
				cp0_wdata.raw = pick_entryhi();
			end
		end
		report_phase("translation");
	endtask

	task automatic raise_exceptions();
		for (int i = 0; i < EXC_CYCLES; i++)
		begin
			@(negedge clk);
			set_idle();
			xlat_req.valid = 1'($urandom);
			xlat_req.store = 1'($urandom);
			xlat_req.vaddr = pick_vaddr();
			exc_req.syscall = ($urandom % 4) == 0;
			exc_req.eret = ($urandom % 5) == 0;
			exc_req.epc = $urandom;
			hw_int = (($urandom % 3) == 0) ? 6'($urandom) : 6'b0;
			cp0_addr = 5'($urandom % 16);
			cp0_wdata.raw = $urandom;
			case ($urandom % 8)
				0, 1:
				begin
					cp0_wen = 1'b1;
					cp0_addr = `CP0_STATUS_ADDR;
				end
				2:
				begin
					cp0_wen = 1'b1;
					cp0_addr = `CP0_EPC_ADDR;
				end
				3:
				begin
					cp0_wen = 1'b1;
					cp0_addr = `CP0_CAUSE_ADDR;
				end
				4:
				begin
					cp0_wen = 1'b1;
					cp0_addr = `CP0_BADVADDR_ADDR;
				end
				default: cp0_wen = 1'b0;
			endcase
		end
		report_phase("exceptions");
	endtask

	task automatic hold_paused();
		for (int i = 0; i < PAUSE_CYCLES; i++)
		begin
			@(negedge clk);
			set_idle();
			cpu_pause = 1'b1;
			cp0_wen = 1'($urandom);
			cp0_addr = 5'($urandom);
			cp0_wdata.raw = $urandom;
			tlb_op = mmu_cp0_pkg::tlb_op_e'(3'($urandom % 5));
			xlat_req.valid = 1'($urandom);
			xlat_req.store = 1'($urandom);
			xlat_req.vaddr = pick_vaddr();
			exc_req.syscall = 1'($urandom);
			exc_req.eret = 1'($urandom);
			exc_req.epc = $urandom;
			hw_int = 6'($urandom);
		end
		report_phase("pause");
	endtask

	initial
	begin
		#(TOTAL_CYCLES * CLK_PERIOD * 2);
		$display("Timeout: the run did not finish within %0d cycles", TOTAL_CYCLES * 2);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hd033d312));
		set_idle();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		exercise_moves();
		watch_random();
		tlb_ops();
		translate_addresses();
		raise_exceptions();
		hold_paused();

		@(negedge clk);
		$display("Summary: %0d checks passed, %0d checks failed", checks - errors, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/cp0_regfile.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmu_cp0_cfg.svh"

module cp0_regfile (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      cpu_pause_i,
	input  logic                      cp0_wen_i,
	input  logic [4:0]                cp0_addr_i,
	input  mmu_cp0_pkg::cp0_word_u    cp0_wdata_i,
	input  mmu_cp0_pkg::tlb_op_e      tlb_op_i,
	input  mmu_cp0_pkg::exc_rec_t     exc_i,
	input  logic                      eret_i,
	input  logic [31:0]               epc_i,
	input  logic                      probe_hit_i,
	input  logic [`MMU_TLB_IDX_W-1:0] probe_idx_i,
	input  mmu_cp0_pkg::tlb_entry_t   rd_entry_i,
	output logic [31:0]               cp0_rdata_o,
	output mmu_cp0_pkg::entryhi_t     entryhi_o,
	output mmu_cp0_pkg::entrylo_t     entrylo0_o,
	output mmu_cp0_pkg::entrylo_t     entrylo1_o,
	output logic                      tlb_wr_en_o,
	output logic [`MMU_TLB_IDX_W-1:0] tlb_wr_idx_o,
	output logic [`MMU_TLB_IDX_W-1:0] tlb_rd_idx_o,
	output mmu_cp0_pkg::status_t      status_o,
	output logic [31:0]               epc_o
);

	logic                      index_p;
	logic [`MMU_TLB_IDX_W-1:0] index_idx;
	logic [`MMU_TLB_IDX_W-1:0] random_q;
	logic [`MMU_TLB_IDX_W-1:0] wired_q;
	mmu_cp0_pkg::entryhi_t     entryhi_q;
	mmu_cp0_pkg::entrylo_t     entrylo0_q;
	mmu_cp0_pkg::entrylo_t     entrylo1_q;
	mmu_cp0_pkg::status_t      status_q;
	logic [5:0]                cause_ip;
	logic [4:0]                cause_code;
	logic [31:0]               badvaddr_q;
	logic [31:0]               epc_q;
	logic                      wr_ok;

	function automatic mmu_cp0_pkg::entrylo_t lo_write(input mmu_cp0_pkg::entrylo_t w);
		mmu_cp0_pkg::entrylo_t lo;
		lo = w;
		lo.zero = '0;
		return lo;
	endfunction

	// C and G are not held in the TLB and stay as they are
	function automatic mmu_cp0_pkg::entrylo_t lo_load(input mmu_cp0_pkg::entrylo_t cur,
		input mmu_cp0_pkg::tlb_half_t half);
		mmu_cp0_pkg::entrylo_t lo;
		lo = cur;
		lo.pfn = half.pfn;
		lo.d = half.d;
		lo.v = half.v;
		return lo;
	endfunction

	assign wr_ok = cp0_wen_i && !cpu_pause_i;

	assign tlb_wr_en_o = !cpu_pause_i &&
		(tlb_op_i == mmu_cp0_pkg::TLBWI || tlb_op_i == mmu_cp0_pkg::TLBWR);
	assign tlb_wr_idx_o = (tlb_op_i == mmu_cp0_pkg::TLBWR) ? random_q : index_idx;
	assign tlb_rd_idx_o = index_idx;

	// Free-running, wraps from the top back to Wired
	always_ff @(posedge clk)
	begin
		if (reset)
			random_q <= '1;
		else if (random_q == '1)
			random_q <= wired_q;
		else
			random_q <= random_q + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			index_p <= 1'b0;
			index_idx <= '0;
			wired_q <= '0;
			entryhi_q <= '0;
			entrylo0_q <= '0;
			entrylo1_q <= '0;
			status_q <= '0;
			cause_ip <= '0;
			cause_code <= '0;
			badvaddr_q <= '0;
			epc_q <= '0;
		end
		else if (!cpu_pause_i)
		begin
			if (wr_ok && cp0_addr_i == `CP0_INDEX_ADDR)
				index_idx <= cp0_wdata_i.raw[`MMU_TLB_IDX_W-1:0];
			else if (tlb_op_i == mmu_cp0_pkg::TLBP)
			begin
				index_p <= !probe_hit_i;
				index_idx <= probe_idx_i;
			end

			if (wr_ok && cp0_addr_i == `CP0_WIRED_ADDR)
				wired_q <= cp0_wdata_i.raw[`MMU_TLB_IDX_W-1:0];

			if (wr_ok && cp0_addr_i == `CP0_ENTRYLO0_ADDR)
				entrylo0_q <= lo_write(cp0_wdata_i.lo);
			else if (tlb_op_i == mmu_cp0_pkg::TLBR)
				entrylo0_q <= lo_load(entrylo0_q, rd_entry_i.even);

			if (wr_ok && cp0_addr_i == `CP0_ENTRYLO1_ADDR)
				entrylo1_q <= lo_write(cp0_wdata_i.lo);
			else if (tlb_op_i == mmu_cp0_pkg::TLBR)
				entrylo1_q <= lo_load(entrylo1_q, rd_entry_i.odd);

			if (wr_ok && cp0_addr_i == `CP0_ENTRYHI_ADDR)
			begin
				entryhi_q.vpn2 <= cp0_wdata_i.hi.vpn2;
				entryhi_q.asid <= cp0_wdata_i.hi.asid;
			end
			else if (tlb_op_i == mmu_cp0_pkg::TLBR)
			begin
				entryhi_q.vpn2 <= rd_entry_i.vpn2;
				entryhi_q.asid <= rd_entry_i.asid;
			end
			// Faulting page for the refill handler
			if (exc_i.valid && exc_i.is_addr)
				entryhi_q.vpn2 <= exc_i.badvaddr[31:13];

			if (wr_ok && cp0_addr_i == `CP0_STATUS_ADDR)
			begin
				status_q.im <= cp0_wdata_i.status.im;
				status_q.um <= cp0_wdata_i.status.um;
				status_q.exl <= cp0_wdata_i.status.exl;
				status_q.ie <= cp0_wdata_i.status.ie;
			end
			if (exc_i.valid)
				status_q.exl <= 1'b1;
			else if (eret_i)
				status_q.exl <= 1'b0;

			if (exc_i.valid)
			begin
				cause_code <= exc_i.code;
				if (exc_i.is_intr)
					cause_ip <= exc_i.ip;
			end
			else if (wr_ok && cp0_addr_i == `CP0_CAUSE_ADDR)
			begin
				cause_ip <= cp0_wdata_i.raw[15:10];
				cause_code <= cp0_wdata_i.raw[6:2];
			end

			if (exc_i.valid)
			begin
				if (exc_i.is_addr)
					badvaddr_q <= exc_i.badvaddr;
			end
			else if (wr_ok && cp0_addr_i == `CP0_BADVADDR_ADDR)
				badvaddr_q <= cp0_wdata_i.raw;

			// Nested exceptions keep the first return address
			if (exc_i.valid)
			begin
				if (!status_q.exl)
					epc_q <= epc_i;
			end
			else if (wr_ok && cp0_addr_i == `CP0_EPC_ADDR)
				epc_q <= cp0_wdata_i.raw;
		end
	end

	always_comb
	begin
		case (cp0_addr_i)
			`CP0_INDEX_ADDR:    cp0_rdata_o = {index_p, {(31-`MMU_TLB_IDX_W){1'b0}}, index_idx};
			`CP0_RANDOM_ADDR:   cp0_rdata_o = {{(32-`MMU_TLB_IDX_W){1'b0}}, random_q};
			`CP0_ENTRYLO0_ADDR: cp0_rdata_o = entrylo0_q;
			`CP0_ENTRYLO1_ADDR: cp0_rdata_o = entrylo1_q;
			`CP0_WIRED_ADDR:    cp0_rdata_o = {{(32-`MMU_TLB_IDX_W){1'b0}}, wired_q};
			`CP0_BADVADDR_ADDR: cp0_rdata_o = badvaddr_q;
			`CP0_ENTRYHI_ADDR:  cp0_rdata_o = entryhi_q;
			`CP0_STATUS_ADDR:   cp0_rdata_o = status_q;
			`CP0_CAUSE_ADDR:    cp0_rdata_o = {16'b0, cause_ip, 3'b0, cause_code, 2'b0};
			`CP0_EPC_ADDR:      cp0_rdata_o = epc_q;
			`CP0_CONFIG_ADDR:   cp0_rdata_o = `CP0_CONFIG_VALUE;
			default:            cp0_rdata_o = '0;
		endcase
	end

	assign entryhi_o = entryhi_q;
	assign entrylo0_o = entrylo0_q;
	assign entrylo1_o = entrylo1_q;
	assign status_o = status_q;
	assign epc_o = epc_q;

endmodule

`default_nettype wire

//--- hdl/exc_prioritizer.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmu_cp0_cfg.svh"

module exc_prioritizer (
	input  mmu_cp0_pkg::xlat_req_t xlat_req_i,
	input  mmu_cp0_pkg::xlat_rsp_t xlat_rsp_i,
	input  mmu_cp0_pkg::exc_req_t  exc_req_i,
	input  logic [5:0]             hw_int_i,
	input  mmu_cp0_pkg::status_t   status_i,
	input  logic                   cpu_pause_i,
	output mmu_cp0_pkg::exc_rec_t  exc_o,
	output logic                   intr_o
);

	logic [5:0] ip;
	logic       intr;
	logic       adr_err;
	logic       tlb_mod;
	logic       tlb_refill;
	logic       tlb_inval;
	logic       addr_type;

	assign ip = hw_int_i & status_i.im;
	assign intr = (|ip) && status_i.ie && !status_i.exl;
	assign intr_o = intr;

	// User access to kseg0 and above
	assign adr_err = xlat_req_i.valid && xlat_rsp_i.addr_err && status_i.um;
	assign tlb_mod = xlat_req_i.valid && xlat_rsp_i.modified;
	assign tlb_refill = xlat_req_i.valid && xlat_rsp_i.refill;
	assign tlb_inval = xlat_req_i.valid && xlat_rsp_i.invalid;
	assign addr_type = adr_err || tlb_mod || tlb_refill || tlb_inval;

	always_comb
	begin
		exc_o = '0;
		exc_o.valid = !cpu_pause_i && (intr || addr_type || exc_req_i.syscall);
		exc_o.is_intr = intr;
		exc_o.is_addr = !intr && addr_type;
		exc_o.ip = ip;
		exc_o.badvaddr = xlat_req_i.vaddr;
		if (intr)
			exc_o.code = `EXC_INT;
		else if (adr_err)
			exc_o.code = xlat_req_i.store ? `EXC_ADES : `EXC_ADEL;
		else if (tlb_mod)
			exc_o.code = `EXC_MOD;
		else if (tlb_refill || tlb_inval)
			exc_o.code = xlat_req_i.store ? `EXC_TLBS : `EXC_TLBL;
		else if (exc_req_i.syscall)
			exc_o.code = `EXC_SYS;
	end

endmodule

`default_nettype wire

//--- hdl/mmu_cp0_cfg.svh
`ifndef MMU_CP0_CFG_SVH
`define MMU_CP0_CFG_SVH

// TLB geometry
`define MMU_TLB_ENTRIES 16
`define MMU_TLB_IDX_W 4

// CP0 register numbers
`define CP0_INDEX_ADDR 5'd0
`define CP0_RANDOM_ADDR 5'd1
`define CP0_ENTRYLO0_ADDR 5'd2
`define CP0_ENTRYLO1_ADDR 5'd3
`define CP0_WIRED_ADDR 5'd6
`define CP0_BADVADDR_ADDR 5'd8
`define CP0_ENTRYHI_ADDR 5'd10
`define CP0_STATUS_ADDR 5'd12
`define CP0_CAUSE_ADDR 5'd13
`define CP0_EPC_ADDR 5'd14
`define CP0_CONFIG_ADDR 5'd16

// Cause.ExcCode values
`define EXC_INT 5'd0
`define EXC_MOD 5'd1
`define EXC_TLBL 5'd2
`define EXC_TLBS 5'd3
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_SYS 5'd8

// M=1, little endian, MT=1, K0=2 (uncached)
`define CP0_CONFIG_VALUE 32'h8000_0082

// kseg0 and kseg1 bypass the TLB
`define MMU_UNMAPPED_LO 32'h8000_0000
`define MMU_UNMAPPED_HI 32'hBFFF_FFFF
`define MMU_UNMAPPED_MASK 32'h1FFF_FFFF

`endif

//--- hdl/mmu_cp0_pkg.sv
`default_nettype none

package mmu_cp0_pkg;

	typedef struct packed {
		logic [18:0] vpn2;
		logic [4:0]  zero;
		logic [7:0]  asid;
	} entryhi_t;

	typedef struct packed {
		logic [5:0]  zero;
		logic [19:0] pfn;
		logic [2:0]  c;
		logic        d;
		logic        v;
		logic        g;
	} entrylo_t;

	typedef struct packed {
		logic [15:0] zero_hi;
		logic [5:0]  im;
		logic [4:0]  zero_mid;
		logic        um;
		logic [1:0]  zero_lo;
		logic        exl;
		logic        ie;
	} status_t;

	// Move-port write word, read according to the target register
	typedef union packed {
		entryhi_t    hi;
		entrylo_t    lo;
		status_t     status;
		logic [31:0] raw;
	} cp0_word_u;

	typedef struct packed {
		logic [19:0] pfn;
		logic        d;
		logic        v;
	} tlb_half_t;

	typedef struct packed {
		logic [18:0] vpn2;
		logic [7:0]  asid;
		tlb_half_t   even;
		tlb_half_t   odd;
	} tlb_entry_t;

	typedef enum logic [2:0] {
		NONE  = 3'd0,
		TLBP  = 3'd1,
		TLBR  = 3'd2,
		TLBWI = 3'd3,
		TLBWR = 3'd4
	} tlb_op_e;

	typedef struct packed {
		logic        valid;
		logic        store;
		logic [31:0] vaddr;
	} xlat_req_t;

	// addr_err flags a kernel-segment address, UM qualifies it later
	typedef struct packed {
		logic [31:0] paddr;
		logic        hit;
		logic        refill;
		logic        invalid;
		logic        modified;
		logic        addr_err;
	} xlat_rsp_t;

	typedef struct packed {
		logic        syscall;
		logic        eret;
		logic [31:0] epc;
	} exc_req_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  code;
		logic        is_addr;
		logic        is_intr;
		logic [5:0]  ip;
		logic [31:0] badvaddr;
	} exc_rec_t;

endpackage

`default_nettype wire

//--- hdl/mmu_cp0_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmu_cp0_cfg.svh"

module mmu_cp0_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cpu_pause_i,
	input  logic                   cp0_wen_i,
	input  logic [4:0]             cp0_addr_i,
	input  mmu_cp0_pkg::cp0_word_u cp0_wdata_i,
	input  mmu_cp0_pkg::tlb_op_e   tlb_op_i,
	input  mmu_cp0_pkg::xlat_req_t xlat_req_i,
	input  mmu_cp0_pkg::exc_req_t  exc_req_i,
	input  logic [5:0]             hw_int_i,
	output logic [31:0]            cp0_rdata_o,
	output mmu_cp0_pkg::xlat_rsp_t xlat_rsp_o,
	output mmu_cp0_pkg::exc_rec_t  exc_o,
	output logic                   intr_o,
	output mmu_cp0_pkg::status_t   status_o,
	output logic [31:0]            epc_o
);

	mmu_cp0_pkg::entryhi_t     entryhi;
	mmu_cp0_pkg::entrylo_t     entrylo0;
	mmu_cp0_pkg::entrylo_t     entrylo1;
	logic                      tlb_wr_en;
	logic [`MMU_TLB_IDX_W-1:0] tlb_wr_idx;
	logic [`MMU_TLB_IDX_W-1:0] tlb_rd_idx;
	logic                      probe_hit;
	logic [`MMU_TLB_IDX_W-1:0] probe_idx;
	mmu_cp0_pkg::tlb_entry_t   rd_entry;

	tlb_cam u_tlb (
		.clk(clk),
		.reset(reset),
		.xlat_req_i(xlat_req_i),
		.entryhi_i(entryhi),
		.entrylo0_i(entrylo0),
		.entrylo1_i(entrylo1),
		.wr_en_i(tlb_wr_en),
		.wr_idx_i(tlb_wr_idx),
		.rd_idx_i(tlb_rd_idx),
		.xlat_rsp_o(xlat_rsp_o),
		.probe_hit_o(probe_hit),
		.probe_idx_o(probe_idx),
		.rd_entry_o(rd_entry)
	);

	exc_prioritizer u_prio (
		.xlat_req_i(xlat_req_i),
		.xlat_rsp_i(xlat_rsp_o),
		.exc_req_i(exc_req_i),
		.hw_int_i(hw_int_i),
		.status_i(status_o),
		.cpu_pause_i(cpu_pause_i),
		.exc_o(exc_o),
		.intr_o(intr_o)
	);

	cp0_regfile u_regs (
		.clk(clk),
		.reset(reset),
		.cpu_pause_i(cpu_pause_i),
		.cp0_wen_i(cp0_wen_i),
		.cp0_addr_i(cp0_addr_i),
		.cp0_wdata_i(cp0_wdata_i),
		.tlb_op_i(tlb_op_i),
		.exc_i(exc_o),
		.eret_i(exc_req_i.eret),
		.epc_i(exc_req_i.epc),
		.probe_hit_i(probe_hit),
		.probe_idx_i(probe_idx),
		.rd_entry_i(rd_entry),
		.cp0_rdata_o(cp0_rdata_o),
		.entryhi_o(entryhi),
		.entrylo0_o(entrylo0),
		.entrylo1_o(entrylo1),
		.tlb_wr_en_o(tlb_wr_en),
		.tlb_wr_idx_o(tlb_wr_idx),
		.tlb_rd_idx_o(tlb_rd_idx),
		.status_o(status_o),
		.epc_o(epc_o)
	);

endmodule

`default_nettype wire

//--- hdl/tlb_cam.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmu_cp0_cfg.svh"

module tlb_cam (
	input  logic                      clk,
	input  logic                      reset,
	input  mmu_cp0_pkg::xlat_req_t    xlat_req_i,
	input  mmu_cp0_pkg::entryhi_t     entryhi_i,
	input  mmu_cp0_pkg::entrylo_t     entrylo0_i,
	input  mmu_cp0_pkg::entrylo_t     entrylo1_i,
	input  logic                      wr_en_i,
	input  logic [`MMU_TLB_IDX_W-1:0] wr_idx_i,
	input  logic [`MMU_TLB_IDX_W-1:0] rd_idx_i,
	output mmu_cp0_pkg::xlat_rsp_t    xlat_rsp_o,
	output logic                      probe_hit_o,
	output logic [`MMU_TLB_IDX_W-1:0] probe_idx_o,
	output mmu_cp0_pkg::tlb_entry_t   rd_entry_o
);

	mmu_cp0_pkg::tlb_entry_t     entries [`MMU_TLB_ENTRIES];
	logic [`MMU_TLB_ENTRIES-1:0] written;

	logic [`MMU_TLB_IDX_W:0]     xlat_match;
	logic [`MMU_TLB_IDX_W:0]     probe_match;
	mmu_cp0_pkg::tlb_entry_t     xlat_entry;
	mmu_cp0_pkg::tlb_half_t      page;
	logic                        unmapped;

	// Returns {hit, index}, lowest matching index wins
	function automatic logic [`MMU_TLB_IDX_W:0] tlb_match(input logic [18:0] vpn2,
		input logic [7:0] asid);
		logic [`MMU_TLB_IDX_W:0] res;
		res = '0;
		for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--)
		begin
			if (written[i] && entries[i].vpn2 == vpn2 && entries[i].asid == asid)
				res = {1'b1, i[`MMU_TLB_IDX_W-1:0]};
		end
		return res;
	endfunction

	// An entry never written cannot match and reads back invalid
	always_ff @(posedge clk)
	begin
		if (reset)
			written <= '0;
		else if (wr_en_i)
			written[wr_idx_i] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (wr_en_i)
		begin
			entries[wr_idx_i].vpn2 <= entryhi_i.vpn2;
			entries[wr_idx_i].asid <= entryhi_i.asid;
			entries[wr_idx_i].even.pfn <= entrylo0_i.pfn;
			entries[wr_idx_i].even.d <= entrylo0_i.d;
			entries[wr_idx_i].even.v <= entrylo0_i.v;
			entries[wr_idx_i].odd.pfn <= entrylo1_i.pfn;
			entries[wr_idx_i].odd.d <= entrylo1_i.d;
			entries[wr_idx_i].odd.v <= entrylo1_i.v;
		end
	end

	// Probe against EntryHi
	always_comb
	begin
		probe_match = tlb_match(entryhi_i.vpn2, entryhi_i.asid);
		probe_hit_o = probe_match[`MMU_TLB_IDX_W];
		probe_idx_o = probe_match[`MMU_TLB_IDX_W-1:0];
	end

	always_comb
	begin
		rd_entry_o = entries[rd_idx_i];
		rd_entry_o.even.v = entries[rd_idx_i].even.v & written[rd_idx_i];
		rd_entry_o.odd.v = entries[rd_idx_i].odd.v & written[rd_idx_i];
	end

	// Data address translation
	always_comb
	begin
		unmapped = xlat_req_i.vaddr >= `MMU_UNMAPPED_LO && xlat_req_i.vaddr <= `MMU_UNMAPPED_HI;
		xlat_match = tlb_match(xlat_req_i.vaddr[31:13], entryhi_i.asid);
		xlat_entry = entries[xlat_match[`MMU_TLB_IDX_W-1:0]];
		page = xlat_req_i.vaddr[12] ? xlat_entry.odd : xlat_entry.even;
		xlat_rsp_o = '0;
		xlat_rsp_o.addr_err = xlat_req_i.vaddr[31];
		if (unmapped)
		begin
			xlat_rsp_o.paddr = xlat_req_i.vaddr & `MMU_UNMAPPED_MASK;
			xlat_rsp_o.hit = 1'b1;
		end
		else if (!xlat_match[`MMU_TLB_IDX_W])
			xlat_rsp_o.refill = 1'b1;
		else if (!page.v)
			xlat_rsp_o.invalid = 1'b1;
		else
		begin
			xlat_rsp_o.paddr = {page.pfn, xlat_req_i.vaddr[11:0]};
			xlat_rsp_o.hit = 1'b1;
			xlat_rsp_o.modified = xlat_req_i.store && !page.d;
		end
	end

endmodule

`default_nettype wire

//--- mmu_cp0.f
+incdir+hdl
hdl/mmu_cp0_pkg.sv
hdl/exc_prioritizer.sv
hdl/tlb_cam.sv
hdl/cp0_regfile.sv
hdl/mmu_cp0_top.sv
dv/mmu_cp0_checker.sv
dv/mmu_cp0_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CP0/MMU testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mmu_cp0_sim
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module mmu_cp0_tb \
	-f mmu_cp0.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
